// File: rtl/audio_pkg.sv
package audio_pkg;

    ////////////////////
    // sample and gain types

    typedef logic signed [23:0] sample_t;   // one pcm channel, 24 significant bits
    typedef logic signed [15:0] gain_t;     // q2.14, range -2.0 to just under 2.0

    ////////////////////
    // fixed point constants

    localparam int GAIN_FRAC = 14;                  // shift after multiply
    localparam gain_t GAIN_UNITY = 16'sh4000;       // 1.0 in q2.14

    localparam sample_t SAMPLE_MAX = 24'sh7f_ffff;  // clamp high
    localparam sample_t SAMPLE_MIN = 24'sh80_0000;  // clamp low

    // bit clocks per channel slot
    // 24 data bits msb first, rest zero
    localparam int SLOT_BITS = 32;

    ////////////////////
    // receiver fsm

    typedef enum logic [1:0] {
        RX_SYNC,    // waiting for first lrclk fall
        RX_LEFT,
        RX_RIGHT
    } rx_state_e;

endpackage

// File: rtl/audio_processing.sv
`timescale 1ns/1ps

module audio_processing #(
    parameter int FIFO_DEPTH = 8,       // frames, power of two
    parameter int TX_SLOTS   = 2,       // transmitter holding slots
    parameter int BCLK_HALF  = 4        // dac half bit clock in clk cycles
) (
    input  logic             clk,
    input  logic             rst,
    // i2s in
    input  logic             i2s_bclk,
    input  logic             i2s_lrclk,
    input  logic             i2s_d,
    // dac out
    output logic             dac_bclk,
    output logic             dac_lrclk,
    output logic             dac_data,
    // cpu gain write
    input  logic             gain_wr,
    input  logic             gain_sel,
    input  audio_pkg::gain_t gain_data,
    // sticky status
    output logic             overflow,
    output logic             underrun
);

    frame_if rx_link ();        // receiver to fifo
    frame_if tx_in_link ();     // fifo to gain
    frame_if tx_out_link ();    // gain to transmitter

    i2s_to_pcm #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i2s_rx (
        .clk      (clk),
        .rst      (rst),
        .bclk     (i2s_bclk),
        .lrclk    (i2s_lrclk),
        .data     (i2s_d),
        .tx       (rx_link.sender),
        .overflow (overflow)
    );

    frame_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .TX_SLOTS   (TX_SLOTS)
    ) fifo (
        .clk (clk),
        .rst (rst),
        .wr  (rx_link.receiver),
        .rd  (tx_in_link.sender)
    );

    eq_gain eq (
        .clk       (clk),
        .rst       (rst),
        .gain_wr   (gain_wr),
        .gain_sel  (gain_sel),
        .gain_data (gain_data),
        .din       (tx_in_link.receiver),
        .dout      (tx_out_link.sender)
    );

    pcm_to_i2s #(
        .TX_SLOTS  (TX_SLOTS),
        .BCLK_HALF (BCLK_HALF)
    ) i2s_tx (
        .clk      (clk),
        .rst      (rst),
        .din      (tx_out_link.receiver),
        .bclk     (dac_bclk),
        .lrclk    (dac_lrclk),
        .data     (dac_data),
        .underrun (underrun)
    );

endmodule

// File: rtl/eq_gain.sv
`timescale 1ns/1ps

module eq_gain (
    input  logic             clk,
    input  logic             rst,
    input  logic             gain_wr,       // cpu write strobe
    input  logic             gain_sel,      // 0 left, 1 right
    input  audio_pkg::gain_t gain_data,
    frame_if.receiver        din,
    frame_if.sender          dout
);

    localparam int PROD_W = $bits(audio_pkg::sample_t) + $bits(audio_pkg::gain_t);
    localparam int QUOT_W = PROD_W - audio_pkg::GAIN_FRAC;

    typedef logic signed [PROD_W-1:0] prod_t;   // full 24x16 product

    audio_pkg::gain_t gain_l;
    audio_pkg::gain_t gain_r;
    prod_t            prod_l;
    prod_t            prod_r;
    logic             valid_s1;

    // drop fraction bits, truncation floors, then clamp
    function automatic audio_pkg::sample_t saturate(input prod_t prod);
        logic signed [QUOT_W-1:0] q;
        q = prod[PROD_W-1:audio_pkg::GAIN_FRAC];
        if (q > audio_pkg::SAMPLE_MAX) begin
            return audio_pkg::SAMPLE_MAX;
        end
        if (q < audio_pkg::SAMPLE_MIN) begin
            return audio_pkg::SAMPLE_MIN;
        end
        return audio_pkg::sample_t'(q);
    endfunction

    ////////////////////
    // gain regs and valid pipe

    always_ff @(posedge clk) begin
        if (rst) begin
            gain_l     <= audio_pkg::GAIN_UNITY;
            gain_r     <= audio_pkg::GAIN_UNITY;
            valid_s1   <= 1'b0;
            dout.valid <= 1'b0;
        end else begin
            if (gain_wr) begin
                if (gain_sel) begin
                    gain_r <= gain_data;
                end else begin
                    gain_l <= gain_data;
                end
            end
            valid_s1   <= din.valid;
            dout.valid <= valid_s1;     // 2 cycle fixed latency
        end
    end

    // stage one multiply, stage two shift and clamp
    always_ff @(posedge clk) begin
        if (din.valid) begin
            prod_l <= prod_t'(din.left) * prod_t'(gain_l);
            prod_r <= prod_t'(din.right) * prod_t'(gain_r);
        end
        if (valid_s1) begin
            dout.left  <= saturate(prod_l);
            dout.right <= saturate(prod_r);
        end
    end

    // no storage here, transmitter credit goes straight to the fifo
    assign din.credit = dout.credit;

endmodule

// File: rtl/frame_fifo.sv
`timescale 1ns/1ps

module frame_fifo #(
    parameter int FIFO_DEPTH = 8,       // power of two, 2 or more
    parameter int TX_SLOTS   = 2        // downstream holding slots
) (
    input  logic      clk,
    input  logic      rst,
    frame_if.receiver wr,
    frame_if.sender   rd
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int CRD_W = $clog2(TX_SLOTS + 1);

    audio_pkg::sample_t left_mem  [FIFO_DEPTH];
    audio_pkg::sample_t right_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;          // frames held
    logic [CRD_W-1:0]   dn_credits;     // free slots in transmitter
    logic               send;

    // oldest frame goes out once there is room downstream
    assign send = (count != '0) && (dn_credits != '0);

    ////////////////////
    // pointers and credits

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            dn_credits <= CRD_W'(TX_SLOTS);
            rd.valid   <= 1'b0;
            wr.credit  <= 1'b0;
        end else begin
            wr_ptr     <= wr_ptr + PTR_W'(wr.valid);     // wraps, depth is 2^n
            rd_ptr     <= rd_ptr + PTR_W'(send);
            count      <= count + CNT_W'(wr.valid) - CNT_W'(send);
            dn_credits <= dn_credits - CRD_W'(send) + CRD_W'(rd.credit);
            rd.valid   <= send;
            wr.credit  <= send;     // slot freed by this send
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (wr.valid) begin
            left_mem[wr_ptr]  <= wr.left;
            right_mem[wr_ptr] <= wr.right;
        end
        if (send) begin
            rd.left  <= left_mem[rd_ptr];
            rd.right <= right_mem[rd_ptr];
        end
    end

endmodule

// File: rtl/frame_if.sv
`timescale 1ns/1ps

// one stereo frame per valid pulse, credit flows back
interface frame_if;

    logic               valid;  // single cycle frame strobe
    audio_pkg::sample_t left;
    audio_pkg::sample_t right;
    logic               credit; // one entry freed at receiver

    // sender spends a credit per valid
    modport sender (
        output valid,
        output left,
        output right,
        input  credit
    );

    // receiver takes every valid frame
    modport receiver (
        input  valid,
        input  left,
        input  right,
        output credit
    );

endinterface

// File: rtl/i2s_to_pcm.sv
`timescale 1ns/1ps

module i2s_to_pcm #(
    parameter int FIFO_DEPTH = 8        // initial credits, space in the fifo
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    bclk,               // async serial clock
    input  logic    lrclk,              // async, low = left
    input  logic    data,               // async serial data
    frame_if.sender tx,
    output logic    overflow            // sticky, frame dropped
);

    localparam int SAMPLE_BITS = $bits(audio_pkg::sample_t);
    localparam int CNT_W       = $clog2(audio_pkg::SLOT_BITS);
    localparam int CRD_W       = $clog2(FIFO_DEPTH + 1);

    logic [1:0]           bclk_sync;
    logic [1:0]           lrclk_sync;
    logic [1:0]           data_sync;
    logic                 bclk_prev;
    logic                 lr_prev;      // lrclk seen at last rising bclk
    logic                 bclk_rise;
    logic                 lr_edge;
    logic                 lr_fall;
    logic                 slot_done;
    logic                 push;
    audio_pkg::rx_state_e state;
    logic [CNT_W-1:0]     bit_cnt;      // data bits taken this slot
    logic [CRD_W-1:0]     credits;
    audio_pkg::sample_t   shreg;
    audio_pkg::sample_t   shreg_next;

    ////////////////////
    // input synchronizer

    always_ff @(posedge clk) begin
        bclk_sync  <= {bclk_sync[0], bclk};
        lrclk_sync <= {lrclk_sync[0], lrclk};
        data_sync  <= {data_sync[0], data};     // aligned with bclk
        bclk_prev  <= bclk_sync[1];
    end

    assign bclk_rise  = bclk_sync[1] & ~bclk_prev;
    assign lr_edge    = lrclk_sync[1] != lr_prev;
    assign lr_fall    = lr_edge & ~lrclk_sync[1];
    assign shreg_next = {shreg[SAMPLE_BITS-2:0], data_sync[1]};

    // 24th data bit of a slot, edge rise carries the old slot's last bit
    assign slot_done = bclk_rise && !lr_edge && (bit_cnt == CNT_W'(SAMPLE_BITS - 1));
    assign push      = slot_done && (state == audio_pkg::RX_RIGHT) && (credits != '0);

    ////////////////////
    // slot fsm and credits

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= audio_pkg::RX_SYNC;
            bit_cnt  <= '0;
            lr_prev  <= 1'b0;
            credits  <= CRD_W'(FIFO_DEPTH);
            tx.valid <= 1'b0;
            overflow <= 1'b0;
        end else begin
            tx.valid <= push;
            credits  <= credits - CRD_W'(push) + CRD_W'(tx.credit);
            if (slot_done && state == audio_pkg::RX_RIGHT && credits == '0) begin
                overflow <= 1'b1;   // no room, frame lost
            end
            if (bclk_rise) begin
                lr_prev <= lrclk_sync[1];
                if (lr_edge) begin
                    bit_cnt <= '0;  // msb follows one bit clock later
                    case (state)
                        audio_pkg::RX_SYNC: begin
                            if (lr_fall) begin
                                state <= audio_pkg::RX_LEFT;
                            end
                        end
                        default: begin
                            state <= lrclk_sync[1] ? audio_pkg::RX_RIGHT : audio_pkg::RX_LEFT;
                        end
                    endcase
                end else if (bit_cnt != CNT_W'(SAMPLE_BITS)) begin
                    bit_cnt <= bit_cnt + 1'b1;  // stops after lsb, padding ignored
                end
            end
        end
    end

    // deserializer and frame payload
    always_ff @(posedge clk) begin
        if (bclk_rise) begin
            shreg <= shreg_next;
        end
        if (slot_done && state == audio_pkg::RX_LEFT) begin
            tx.left <= shreg_next;
        end
        if (slot_done && state == audio_pkg::RX_RIGHT) begin
            tx.right <= shreg_next;     // lands with valid
        end
    end

endmodule

// File: rtl/pcm_to_i2s.sv
`timescale 1ns/1ps

module pcm_to_i2s #(
    parameter int TX_SLOTS  = 2,        // holding buffer depth
    parameter int BCLK_HALF = 4         // clk cycles per half bit clock
) (
    input  logic      clk,
    input  logic      rst,
    frame_if.receiver din,
    output logic      bclk,
    output logic      lrclk,            // low = left
    output logic      data,
    output logic      underrun          // sticky, silence sent
);

    localparam int SAMPLE_BITS = $bits(audio_pkg::sample_t);
    localparam int BIT_W       = $clog2(audio_pkg::SLOT_BITS);
    localparam int DIV_W       = (BCLK_HALF > 1) ? $clog2(BCLK_HALF) : 1;
    localparam int PTR_W       = (TX_SLOTS > 1) ? $clog2(TX_SLOTS) : 1;
    localparam int CNT_W       = $clog2(TX_SLOTS + 1);

    audio_pkg::sample_t hold_l [TX_SLOTS];
    audio_pkg::sample_t hold_r [TX_SLOTS];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;          // frames waiting
    logic [DIV_W-1:0]   div_cnt;
    logic [BIT_W-1:0]   bit_cnt;        // bit position in slot
    logic               half_tick;
    logic               bclk_fall;
    logic               slot_end;
    logic               left_start;
    logic               take;
    audio_pkg::sample_t shreg;          // current slot, msb out first
    audio_pkg::sample_t right_next;     // right half of the playing frame

    // holding buffer depth need not be 2^n
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(TX_SLOTS - 1)) ? '0 : p + 1'b1;
    endfunction

    assign half_tick  = div_cnt == DIV_W'(BCLK_HALF - 1);
    assign bclk_fall  = half_tick && bclk;
    assign slot_end   = bclk_fall && (bit_cnt == BIT_W'(audio_pkg::SLOT_BITS - 1));
    assign left_start = slot_end && lrclk;             // lrclk about to fall
    assign take       = left_start && (count != '0);

    ////////////////////
    // clocks, serializer, buffer control

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt    <= '0;
            bclk       <= 1'b0;
            lrclk      <= 1'b0;
            bit_cnt    <= '0;
            data       <= 1'b0;
            shreg      <= '0;
            right_next <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            din.credit <= 1'b0;
            underrun   <= 1'b0;
        end else begin
            div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
            if (half_tick) begin
                bclk <= ~bclk;
            end
            if (bclk_fall) begin
                bit_cnt <= slot_end ? '0 : bit_cnt + 1'b1;
                if (slot_end) begin
                    lrclk <= ~lrclk;
                    data  <= 1'b0;  // last bit of old slot is padding
                    if (lrclk) begin
                        shreg      <= take ? hold_l[rd_ptr] : '0;
                        right_next <= take ? hold_r[rd_ptr] : '0;
                    end else begin
                        shreg <= right_next;
                    end
                end else begin
                    data  <= shreg[SAMPLE_BITS-1];
                    shreg <= {shreg[SAMPLE_BITS-2:0], 1'b0};  // zeros after lsb
                end
            end
            if (din.valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (take) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count      <= count + CNT_W'(din.valid) - CNT_W'(take);
            din.credit <= take;     // slot handed back to fifo
            if (left_start && count == '0) begin
                underrun <= 1'b1;
            end
        end
    end

    // holding slots
    always_ff @(posedge clk) begin
        if (din.valid) begin
            hold_l[wr_ptr] <= din.left;
            hold_r[wr_ptr] <= din.right;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_audio_processing \
    -f sources.f -Mdir obj_dir -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Test passed" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported failure"
    exit 1
fi

// File: sources.f
rtl/audio_pkg.sv
rtl/frame_if.sv
rtl/i2s_to_pcm.sv
rtl/frame_fifo.sv
rtl/eq_gain.sv
rtl/pcm_to_i2s.sv
rtl/audio_processing.sv
testbench/tb_clock.sv
testbench/tb_audio_processing.sv

// File: testbench/tb_audio_processing.sv
`timescale 1ns/1ps

module tb_audio_processing;

    localparam int FIFO_DEPTH      = 8;
    localparam int TX_SLOTS        = 2;
    localparam int BCLK_HALF       = 4;
    localparam int SAMPLE_BITS     = $bits(audio_pkg::sample_t);
    localparam int N_PASS          = 40;
    localparam int N_GAIN          = 40;
    localparam int N_OVF           = FIFO_DEPTH * 4;
    localparam int FRAME_CLKS      = 2 * audio_pkg::SLOT_BITS * 2 * BCLK_HALF;
    localparam int TOTAL_FRAMES    = N_PASS + N_GAIN + N_OVF + 24;  // plus idle gaps
    localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * FRAME_CLKS * 2;

    logic             clk;
    logic             rst;
    logic             i2s_bclk;
    logic             i2s_lrclk;
    logic             i2s_d;
    logic             dac_bclk;
    logic             dac_lrclk;
    logic             dac_data;
    logic             gain_wr;
    logic             gain_sel;
    audio_pkg::gain_t gain_data;
    logic             overflow;
    logic             underrun;

    audio_pkg::sample_t exp_l [$];      // model output oldest first
    audio_pkg::sample_t exp_r [$];
    audio_pkg::gain_t   model_gain_l = audio_pkg::GAIN_UNITY;
    audio_pkg::gain_t   model_gain_r = audio_pkg::GAIN_UNITY;
    audio_pkg::sample_t last_l       = '0;  // last decoded frame
    audio_pkg::sample_t last_r       = '0;
    int                 errors       = 0;
    int                 tests_ok     = 0;
    int                 tests_bad    = 0;
    int                 frames_out   = 0;   // decoded frames so far
    int                 zero_frames  = 0;   // silent frames seen so far
    int                 matched      = 0;
    int                 dropped      = 0;
    bit                 started      = 1'b0;    // first expected frame seen
    bit                 lossy        = 1'b0;    // drops allowed

    // output decoder state
    logic               dec_lr        = 1'b0;
    int                 dec_bit       = SAMPLE_BITS;    // idle until an lrclk edge
    audio_pkg::sample_t dec_shift     = '0;
    audio_pkg::sample_t dec_left      = '0;
    bit                 dec_have_left = 1'b0;

    tb_clock clkgen (
        .clk (clk),
        .rst (rst)
    );

    audio_processing #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .TX_SLOTS   (TX_SLOTS),
        .BCLK_HALF  (BCLK_HALF)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .i2s_bclk  (i2s_bclk),
        .i2s_lrclk (i2s_lrclk),
        .i2s_d     (i2s_d),
        .dac_bclk  (dac_bclk),
        .dac_lrclk (dac_lrclk),
        .dac_data  (dac_data),
        .gain_wr   (gain_wr),
        .gain_sel  (gain_sel),
        .gain_data (gain_data),
        .overflow  (overflow),
        .underrun  (underrun)
    );

    ////////////////////
    // model and helpers

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // sample times gain with floor shift and 24 bit clamp
    function automatic audio_pkg::sample_t scale(input audio_pkg::sample_t s,
                                                 input audio_pkg::gain_t g);
        longint p;
        p = (longint'(s) * longint'(g)) >>> audio_pkg::GAIN_FRAC;
        if (p > longint'(audio_pkg::SAMPLE_MAX)) begin
            return audio_pkg::SAMPLE_MAX;
        end
        if (p < longint'(audio_pkg::SAMPLE_MIN)) begin
            return audio_pkg::SAMPLE_MIN;
        end
        return audio_pkg::sample_t'(p);
    endfunction

    // extremes one time in four and never zero
    function automatic audio_pkg::sample_t rand_sample();
        int unsigned        pick;
        audio_pkg::sample_t v;
        pick = $urandom % 8;
        if (pick == 0) begin
            return audio_pkg::SAMPLE_MAX;
        end
        if (pick == 1) begin
            return audio_pkg::SAMPLE_MIN;
        end
        v = audio_pkg::sample_t'($urandom);
        if (v == '0) begin
            v = 24'sd1;
        end
        return v;
    endfunction

    // one i2s slot with data moving while bclk is low
    task automatic drive_slot(input logic lr, input audio_pkg::sample_t value, input int half);
        for (int i = 0; i < audio_pkg::SLOT_BITS; i++) begin
            @(negedge clk);
            i2s_bclk  = 1'b0;
            i2s_lrclk = lr;
            i2s_d     = (i >= 1 && i <= SAMPLE_BITS) ? value[SAMPLE_BITS - i] : 1'b0;
            repeat (half) @(negedge clk);
            i2s_bclk = 1'b1;    // receiver samples here
            repeat (half - 1) @(negedge clk);
        end
    endtask

    task automatic send_frames(input int count, input int half);
        audio_pkg::sample_t l;
        audio_pkg::sample_t r;
        for (int n = 0; n < count; n++) begin
            l = rand_sample();
            r = rand_sample();
            exp_l.push_back(scale(l, model_gain_l));   // queued before it can come out
            exp_r.push_back(scale(r, model_gain_r));
            drive_slot(1'b0, l, half);
            drive_slot(1'b1, r, half);
        end
    endtask

    task automatic write_gain(input logic sel, input audio_pkg::gain_t value);
        @(negedge clk);
        gain_wr   = 1'b1;
        gain_sel  = sel;
        gain_data = value;
        @(negedge clk);
        gain_wr = 1'b0;
        if (sel) begin
            model_gain_r = value;
        end else begin
            model_gain_l = value;
        end
    endtask

    task automatic wait_drained();
        while (exp_l.size() != 0) @(negedge clk);
    endtask

    // two more silent frames mean the chain is empty
    task automatic wait_idle();
        int z0;
        z0 = zero_frames;
        while (zero_frames < z0 + 2) @(negedge clk);
    endtask

    // block until the decoder has taken n more frames
    task automatic wait_frames(input int n);
        int f0;
        f0 = frames_out;
        while (frames_out < f0 + n) @(negedge clk);
    endtask

    task automatic check_outputs_low();
        check("dac_bclk", 0, dac_bclk);
        check("dac_lrclk", 0, dac_lrclk);
        check("dac_data", 0, dac_data);
        check("overflow", 0, overflow);
        check("underrun", 0, underrun);
    endtask

    task automatic finish_test(input string name, input int err_mark);
        if (errors == err_mark) begin
            tests_ok++;
            $display("[ok]    %s", name);
        end else begin
            tests_bad++;
            $display("[error] %s, %0d checks failed", name, errors - err_mark);
        end
    endtask

    ////////////////////
    // output decoder

    // compare one decoded frame against the queue
    task automatic take_frame(input audio_pkg::sample_t l, input audio_pkg::sample_t r);
        int hit;
        hit    = -1;
        last_l = l;
        last_r = r;
        frames_out++;
        if (l == '0 && r == '0) begin
            zero_frames++;
            if (!started || lossy || exp_l.size() == 0) begin
                return;     // silence while idle or filling
            end
        end
        if (exp_l.size() == 0) begin
            errors++;
            $display("output frame %h %h appeared while no frame was sent", l, r);
            return;
        end
        if (!lossy) begin
            check("dac left", exp_l[0], l);
            check("dac right", exp_r[0], r);
            void'(exp_l.pop_front());
            void'(exp_r.pop_front());
            started = 1'b1;
            return;
        end
        for (int i = 0; i < exp_l.size(); i++) begin
            if (hit < 0 && exp_l[i] == l && exp_r[i] == r) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            errors++;
            $display("output frame %h %h is out of order or was never sent", l, r);
            return;
        end
        dropped += hit;     // skipped frames were lost at the receiver
        repeat (hit + 1) begin
            void'(exp_l.pop_front());
            void'(exp_r.pop_front());
        end
        matched++;
        started = 1'b1;
    endtask

    always @(posedge dac_bclk) begin
        if (dac_lrclk != dec_lr) begin
            dec_lr  = dac_lrclk;
            dec_bit = 0;    // delay bit before the msb
        end else if (dec_bit < SAMPLE_BITS) begin
            dec_shift = {dec_shift[SAMPLE_BITS-2:0], dac_data};
            dec_bit++;
            if (dec_bit == SAMPLE_BITS && !dec_lr) begin
                dec_left      = dec_shift;
                dec_have_left = 1'b1;
            end else if (dec_bit == SAMPLE_BITS && dec_have_left) begin
                dec_have_left = 1'b0;
                take_frame(dec_left, dec_shift);
            end
        end
    end

    ////////////////////
    // tests

    initial begin
        int err_mark;
        void'($urandom(32'h84acbf6f));
        i2s_bclk  = 1'b0;
        i2s_lrclk = 1'b0;
        i2s_d     = 1'b0;
        gain_wr   = 1'b0;
        gain_sel  = 1'b0;
        gain_data = '0;

        err_mark = errors;
        repeat (2) @(negedge clk);
        check_outputs_low();        // inside reset
        @(negedge rst);
        @(negedge clk);
        check_outputs_low();        // first cycle out of reset
        finish_test("reset state", err_mark);

        err_mark = errors;
        drive_slot(1'b1, '0, BCLK_HALF);    // one lrclk high slot so the receiver syncs
        send_frames(N_PASS, BCLK_HALF);
        wait_drained();
        wait_idle();
        check("overflow", 0, overflow);
        finish_test("unity passthrough", err_mark);

        err_mark = errors;
        write_gain(1'b0, 16'sh2000);    // 0.5
        write_gain(1'b1, 16'sh7000);    // 1.75 clamps the extremes
        started = 1'b0;
        send_frames(N_GAIN, BCLK_HALF);
        wait_drained();
        wait_idle();
        finish_test("per-channel gain with saturation", err_mark);

        err_mark = errors;
        wait_frames(2);
        check("underrun", 1, underrun);
        check("silent left", 0, last_l);
        check("silent right", 0, last_r);
        finish_test("underrun", err_mark);

        err_mark = errors;
        started = 1'b0;
        lossy   = 1'b1;
        send_frames(N_OVF, BCLK_HALF / 2);  // input twice the output rate
        wait_idle();
        dropped += exp_l.size();
        exp_l.delete();
        exp_r.delete();
        check("overflow", 1, overflow);
        check("frames matched", 1, 32'(matched != 0));
        check("frames dropped", 1, 32'(dropped != 0));
        finish_test("overflow", err_mark);

        $display("summary: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // bound from frame count and frame length
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD       = 4.0,  // ns
    parameter int  RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule
